// File: dbg_settings.svh
/*
  shared widths, address fields and register indices of the debug unit
  include wherever a width or a decode constant is needed
*/

`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// widths --------------------
`define DBG_ADDR_W  15 // debug bus address
`define DBG_DATA_W  32 // bus and register data
`define DBG_GPR_AW  5  // register file index, addr[6:2]
`define DBG_CAUSE_W 6  // trap cause
`define DBG_SETS_W  5  // settings vector to the core

// address regions in addr[13:8] --------------------
`define DBG_REGION_ALWAYS 6'h00 // always accessible debug regs
`define DBG_REGION_HALTED 6'h20 // only while halted
`define DBG_REGION_GPR    6'h04 // general purpose registers

// register indices in addr[6:2] --------------------
`define DBG_IDX_CTRL  5'd0
`define DBG_IDX_HIT   5'd1
`define DBG_IDX_IE    5'd2
`define DBG_IDX_CAUSE 5'd3
`define DBG_IDX_DNPC  5'd0 // halted region

// CTRL halt/resume bit
`define DBG_CTRL_HALT_BIT 16

// cause for a non-trap halt, also the reset value
`define DBG_CAUSE_HALT 6'h1F

`endif

// File: dbg_pkg.sv
/*
  types shared by the debug unit modules and interfaces
  referenced by scoped name, never imported
*/

`default_nettype none

`include "dbg_settings.svh"

package dbg_pkg;

  // source of the bus read data in the rvalid cycle
  typedef enum logic [1:0] {
    RD_NONE = 2'd0, // unmapped or blocked, reads 0
    RD_GPR  = 2'd1, // register file
    RD_DBG  = 2'd2  // always-accessible debug regs
  } dbg_rd_sel_e;

  // halt controller states
  typedef enum logic [1:0] {
    RUNNING  = 2'd0,
    HALT_REQ = 2'd1, // waiting for core ack
    HALT     = 2'd2
  } dbg_halt_state_e;

  // settings to the core, msb first on the vector
  typedef struct packed {
    logic sste;  // single step enable
    logic ecall; // trap on ecall
    logic elsu;  // trap on load/store misalign
    logic ebrk;  // trap on ebreak
    logic eill;  // trap on illegal instr
  } dbg_settings_t;

  typedef logic [`DBG_CAUSE_W-1:0] dbg_cause_t;

endpackage

`default_nettype wire

// File: dbg_access_if.sv
/*
  decoded debug register accesses, bus decoder to register block
  write strobe in the request cycle, latched read select/index after it
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

interface dbg_access_if;

  logic                     reg_we;    // write pulse, always region
  logic [`DBG_GPR_AW-1:0]   reg_idx;   // register index of the write
  logic [`DBG_DATA_W-1:0]   reg_wdata;
  dbg_pkg::dbg_rd_sel_e     rd_sel_q;  // latched read source
  logic [`DBG_GPR_AW-1:0]   rd_idx_q;  // latched read index

  modport dec (output reg_we, reg_idx, reg_wdata, rd_sel_q, rd_idx_q);
  modport regs (input reg_we, reg_idx, reg_wdata, rd_sel_q, rd_idx_q);

endinterface

`default_nettype wire

// File: dbg_status_if.sv
/*
  halt commands and halt status shared by registers, halt controller and decoder
  commands are single cycle pulses from the register block
*/

`timescale 1ns/10ps
`default_nettype none

interface dbg_status_if;

  logic                 halt_cmd;   // CTRL write, halt bit set
  logic                 resume_cmd; // CTRL write, halt bit clear
  logic                 ssth_clear; // HIT write, bit 0 set
  logic                 halted;     // core is in HALT
  dbg_pkg::dbg_cause_t  cause_q;
  logic                 ssth_q;     // single step hit

  // register block, issues commands and reads status back
  modport cmd (output halt_cmd, resume_cmd, ssth_clear,
               input halted, cause_q, ssth_q);
  // halt controller
  modport ctrl (input halt_cmd, resume_cmd, ssth_clear,
                output halted, cause_q, ssth_q);
  // bus decoder, gates GPR and DNPC access
  modport obs (input halted);

endinterface

`default_nettype wire

// File: dbg_bus_decoder.sv
/*
  debug bus front end, grants every request at once and returns rvalid a cycle later
  decodes regions, raises GPR and jump requests while halted, muxes read data
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_bus_decoder (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    debug_req_i,
  input  wire                    debug_we_i,
  input  wire  [`DBG_ADDR_W-1:0] debug_addr_i,
  input  wire  [`DBG_DATA_W-1:0] debug_wdata_i,
  output logic                   debug_gnt_o,
  output logic                   debug_rvalid_o,
  output logic [`DBG_DATA_W-1:0] debug_rdata_o,
  input  wire  [`DBG_DATA_W-1:0] regfile_rdata_i,
  input  wire  [`DBG_DATA_W-1:0] debug_data_i,   // debug reg read value
  output logic                   regfile_rreq_o,
  output logic [`DBG_GPR_AW-1:0] regfile_raddr_o,
  output logic                   regfile_wreq_o,
  output logic [`DBG_GPR_AW-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0] regfile_wdata_o,
  output logic                   jump_req_o,
  output logic [`DBG_DATA_W-1:0] jump_addr_o,
  dbg_access_if.dec              acc,
  dbg_status_if.obs              stat
);

  logic [5:0]             region;
  logic [`DBG_GPR_AW-1:0] idx;
  logic                   hit_always, hit_halted, hit_gpr;
  logic                   rd_req, wr_req;
  dbg_pkg::dbg_rd_sel_e   rd_sel_n, rd_sel_q;
  logic                   rreq_q, jump_q;
  logic [`DBG_GPR_AW-1:0] idx_q;
  logic [`DBG_DATA_W-1:0] wdata_q; // jump target

  // decode --------------------
  assign region = debug_addr_i[13:8];
  assign idx    = debug_addr_i[6:2];

  // bit 14 set is unmapped space
  assign hit_always = ~debug_addr_i[14] & (region == `DBG_REGION_ALWAYS);
  assign hit_halted = ~debug_addr_i[14] & (region == `DBG_REGION_HALTED);
  assign hit_gpr    = ~debug_addr_i[14] & (region == `DBG_REGION_GPR);

  assign rd_req = debug_req_i & ~debug_we_i;
  assign wr_req = debug_req_i & debug_we_i;

  assign debug_gnt_o = debug_req_i; // no back-pressure for any address

  // always-region writes go straight to the register block
  assign acc.reg_we    = wr_req & hit_always;
  assign acc.reg_idx   = idx;
  assign acc.reg_wdata = debug_wdata_i;

  // GPR write in the request cycle while halted
  assign regfile_wreq_o  = wr_req & hit_gpr & stat.halted;
  assign regfile_waddr_o = idx;
  assign regfile_wdata_o = debug_wdata_i;

  always_comb begin
    rd_sel_n = dbg_pkg::RD_NONE;
    if (rd_req) begin
      if (hit_always)
        rd_sel_n = dbg_pkg::RD_DBG;
      else if (hit_gpr && stat.halted)
        rd_sel_n = dbg_pkg::RD_GPR; // running gpr reads return 0
    end
  end

  // request latches --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      rd_sel_q       <= dbg_pkg::RD_NONE;
      rreq_q         <= 1'b0;
      jump_q         <= 1'b0;
    end else begin
      debug_rvalid_o <= debug_gnt_o; // rvalid one cycle after each gnt
      if (debug_req_i || debug_rvalid_o) begin // idle otherwise
        rd_sel_q <= rd_sel_n;
        rreq_q   <= rd_req & hit_gpr & stat.halted;
        jump_q   <= wr_req & hit_halted & stat.halted & (idx == `DBG_IDX_DNPC);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      idx_q   <= idx;
      wdata_q <= debug_wdata_i;
    end
  end

  assign acc.rd_sel_q = rd_sel_q;
  assign acc.rd_idx_q = idx_q;

  assign regfile_rreq_o  = rreq_q; // high in the rvalid cycle with the data
  assign regfile_raddr_o = idx_q;
  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

  // read data mux --------------------
  always_comb begin
    case (rd_sel_q)
      dbg_pkg::RD_GPR: debug_rdata_o = regfile_rdata_i;
      dbg_pkg::RD_DBG: debug_rdata_o = debug_data_i;
      default:         debug_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: dbg_regs.sv
/*
  always-accessible debug registers CTRL, HIT, IE and CAUSE
  holds the settings, turns CTRL/HIT writes into halt controller commands
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  output dbg_pkg::dbg_settings_t  settings_o,
  output logic [`DBG_DATA_W-1:0]  debug_data_o,
  dbg_access_if.regs              acc,
  dbg_status_if.cmd               stat
);

  dbg_pkg::dbg_settings_t settings_q;
  logic                   ctrl_we, hit_we, ie_we;

  assign ctrl_we = acc.reg_we & (acc.reg_idx == `DBG_IDX_CTRL);
  assign hit_we  = acc.reg_we & (acc.reg_idx == `DBG_IDX_HIT);
  assign ie_we   = acc.reg_we & (acc.reg_idx == `DBG_IDX_IE);

  // commands in the same cycle as the write
  assign stat.halt_cmd   = ctrl_we & acc.reg_wdata[`DBG_CTRL_HALT_BIT];
  assign stat.resume_cmd = ctrl_we & ~acc.reg_wdata[`DBG_CTRL_HALT_BIT];
  assign stat.ssth_clear = hit_we & acc.reg_wdata[0];

  // settings --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q <= '0;
    end else begin
      if (ctrl_we)
        settings_q.sste <= acc.reg_wdata[0];
      if (ie_we) begin
        settings_q.ecall <= acc.reg_wdata[11];
        settings_q.elsu  <= acc.reg_wdata[7] | acc.reg_wdata[5]; // load or store
        settings_q.ebrk  <= acc.reg_wdata[3];
        settings_q.eill  <= acc.reg_wdata[2];
      end
    end
  end

  assign settings_o = settings_q;

  // read mux on the latched index --------------------
  always_comb begin
    debug_data_o = '0;
    if (acc.rd_sel_q == dbg_pkg::RD_DBG) begin
      case (acc.rd_idx_q)
        `DBG_IDX_CTRL: begin
          debug_data_o[`DBG_CTRL_HALT_BIT] = stat.halted;
          debug_data_o[0]                  = settings_q.sste;
        end
        `DBG_IDX_HIT: debug_data_o[0] = stat.ssth_q; // upper bits read 0
        `DBG_IDX_IE: begin
          debug_data_o[11] = settings_q.ecall;
          debug_data_o[7]  = settings_q.elsu; // shown twice
          debug_data_o[5]  = settings_q.elsu;
          debug_data_o[3]  = settings_q.ebrk;
          debug_data_o[2]  = settings_q.eill;
        end
        `DBG_IDX_CAUSE: debug_data_o = {stat.cause_q[5], 26'b0, stat.cause_q[4:0]};
        default: debug_data_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dbg_halt_ctrl.sv
/*
  halt state machine, RUNNING -> HALT_REQ -> HALT and back
  records the trap cause and the single-step hit on entry to HALT_REQ
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_halt_ctrl (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    debug_halt_i,
  input  wire                    debug_resume_i,
  input  wire                    trap_i,
  input  wire  [`DBG_CAUSE_W-1:0] exc_cause_i,
  input  wire                    dbg_ack_i,
  input  wire                    sste_i,
  output logic                   dbg_req_o,
  output logic                   stall_o,
  dbg_status_if.ctrl             stat
);

  dbg_pkg::dbg_halt_state_e state_q, state_n;
  dbg_pkg::dbg_cause_t      cause_q, cause_n;
  logic                     ssth_q, ssth_n;

  // next state --------------------
  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    ssth_n    = ssth_q;
    dbg_req_o = 1'b0;
    stall_o   = 1'b0;

    case (state_q)
      dbg_pkg::RUNNING: begin
        ssth_n = 1'b0;
        if (stat.halt_cmd || debug_halt_i || trap_i) begin
          dbg_req_o = 1'b1; // same cycle as the request
          state_n   = dbg_pkg::HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = sste_i; // hit only when stepping
          end else begin
            cause_n = `DBG_CAUSE_HALT;
          end
        end
      end

      dbg_pkg::HALT_REQ: begin
        dbg_req_o = 1'b1; // hold until ack
        if (dbg_ack_i)
          state_n = dbg_pkg::HALT;
        if (debug_resume_i)
          state_n = dbg_pkg::RUNNING; // external resume wins
      end

      dbg_pkg::HALT: begin
        stall_o = 1'b1;
        if (stat.resume_cmd || debug_resume_i) begin
          stall_o = 1'b0; // release in the resume cycle
          state_n = dbg_pkg::RUNNING;
        end
      end

      default: state_n = dbg_pkg::RUNNING;
    endcase

    if (stat.ssth_clear)
      ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dbg_pkg::RUNNING;
      cause_q <= `DBG_CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign stat.halted  = (state_q == dbg_pkg::HALT);
  assign stat.cause_q = cause_q;
  assign stat.ssth_q  = ssth_q;

endmodule

`default_nettype wire

// File: dbg_unit_top.sv
/*
  debug unit top level, plain bus, core and register file ports
  connects decoder, register block and halt controller through two interfaces
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_unit_top (
  input  wire                     clk,
  input  wire                     rst_n,
  // debug bus
  input  wire                     debug_req_i,
  output logic                    debug_gnt_o,
  output logic                    debug_rvalid_o,
  input  wire  [`DBG_ADDR_W-1:0]  debug_addr_i,
  input  wire                     debug_we_i,
  input  wire  [`DBG_DATA_W-1:0]  debug_wdata_i,
  output logic [`DBG_DATA_W-1:0]  debug_rdata_o,
  output logic                    debug_halted_o,
  input  wire                     debug_halt_i,
  input  wire                     debug_resume_i,
  // core side
  output logic [`DBG_SETS_W-1:0]  settings_o,
  input  wire                     trap_i,
  input  wire  [`DBG_CAUSE_W-1:0] exc_cause_i,
  output logic                    stall_o,
  output logic                    dbg_req_o,
  input  wire                     dbg_ack_i,
  // register file
  output logic                    regfile_rreq_o,
  output logic [`DBG_GPR_AW-1:0]  regfile_raddr_o,
  input  wire  [`DBG_DATA_W-1:0]  regfile_rdata_i,
  output logic                    regfile_wreq_o,
  output logic [`DBG_GPR_AW-1:0]  regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0]  regfile_wdata_o,
  // jump to DNPC
  output logic                    jump_req_o,
  output logic [`DBG_DATA_W-1:0]  jump_addr_o
);

  dbg_access_if acc_if ();
  dbg_status_if stat_if ();

  dbg_pkg::dbg_settings_t settings;
  logic [`DBG_DATA_W-1:0] debug_data; // debug reg read value

  dbg_bus_decoder u_dbg_bus_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_we_i      (debug_we_i),
    .debug_addr_i    (debug_addr_i),
    .debug_wdata_i   (debug_wdata_i),
    .debug_gnt_o     (debug_gnt_o),
    .debug_rvalid_o  (debug_rvalid_o),
    .debug_rdata_o   (debug_rdata_o),
    .regfile_rdata_i (regfile_rdata_i),
    .debug_data_i    (debug_data),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o),
    .acc             (acc_if.dec),
    .stat            (stat_if.obs)
  );

  dbg_regs u_dbg_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .settings_o   (settings),
    .debug_data_o (debug_data),
    .acc          (acc_if.regs),
    .stat         (stat_if.cmd)
  );

  dbg_halt_ctrl u_dbg_halt_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .debug_halt_i   (debug_halt_i),
    .debug_resume_i (debug_resume_i),
    .trap_i         (trap_i),
    .exc_cause_i    (exc_cause_i),
    .dbg_ack_i      (dbg_ack_i),
    .sste_i         (settings.sste),
    .dbg_req_o      (dbg_req_o),
    .stall_o        (stall_o),
    .stat           (stat_if.ctrl)
  );

  assign settings_o     = settings; // packed struct onto the flat port
  assign debug_halted_o = stat_if.halted;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
  testbench clock and reset source for the debug unit
  free running clock, reset held low for the first cycles
*/

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS   = 40, // full clock period
  parameter int RST_CYCLES  = 4   // cycles with rst_n low
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o); // release away from the active edge
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_dbg_unit.sv
/*
  table driven testbench for the debug unit top level
  bus, halt, trap and ack steps applied in a loop, inputs change on the falling edge
  register file model answers GPR reads and records GPR writes
*/

`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module tb_dbg_unit;

  localparam int CLK_PERIOD_NS = 40;
  localparam int MAX_STEPS     = 64;

  typedef enum logic [3:0] {
    OP_WR, OP_RD,         // plain bus write, bus read with expected data
    OP_RND_WR, OP_RND_RD, // bus write/read of a random word
    OP_MODEL,             // register file model still holds the random word
    OP_JUMP,              // DNPC write, expect jump one cycle later
    OP_HALT, OP_RESUME, OP_TRAP, OP_ACK, // one-cycle input pulses
    OP_SETS,              // settings_o against exp
    OP_STAT               // {halted, stall, dbg_req} against exp
  } op_e;

  typedef struct packed {
    op_e                    op;
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] data;
    dbg_pkg::dbg_cause_t    cause;
    logic [`DBG_DATA_W-1:0] exp;
  } step_t;

  // DUT signals --------------------
  logic                    clk, rst_n;
  logic                    debug_req, debug_we, debug_gnt, debug_rvalid;
  logic [`DBG_ADDR_W-1:0]  debug_addr;
  logic [`DBG_DATA_W-1:0]  debug_wdata, debug_rdata;
  logic                    debug_halted, debug_halt, debug_resume;
  logic [`DBG_SETS_W-1:0]  settings;
  logic                    trap, stall, dbg_req, dbg_ack;
  logic [`DBG_CAUSE_W-1:0] exc_cause;
  logic                    regfile_rreq, regfile_wreq, jump_req;
  logic [`DBG_GPR_AW-1:0]  regfile_raddr, regfile_waddr;
  logic [`DBG_DATA_W-1:0]  regfile_rdata, regfile_wdata, jump_addr;

  // testbench state
  step_t                  steps [MAX_STEPS];
  int                     n_steps = 0;
  logic                   table_ready = 1'b0;
  integer                 seed = 47339;
  logic [`DBG_DATA_W-1:0] rf_model [32];
  logic [`DBG_DATA_W-1:0] rd_word, rnd_word, jump_target;
  logic                   jump_seen;
  logic                   rreq_seen;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(4)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dbg_unit_top dbg_unit_top_i (
    .clk (clk), .rst_n (rst_n),
    .debug_req_i (debug_req), .debug_gnt_o (debug_gnt), .debug_rvalid_o (debug_rvalid),
    .debug_addr_i (debug_addr), .debug_we_i (debug_we), .debug_wdata_i (debug_wdata),
    .debug_rdata_o (debug_rdata), .debug_halted_o (debug_halted),
    .debug_halt_i (debug_halt), .debug_resume_i (debug_resume),
    .settings_o (settings), .trap_i (trap), .exc_cause_i (exc_cause),
    .stall_o (stall), .dbg_req_o (dbg_req), .dbg_ack_i (dbg_ack),
    .regfile_rreq_o (regfile_rreq), .regfile_raddr_o (regfile_raddr),
    .regfile_rdata_i (regfile_rdata), .regfile_wreq_o (regfile_wreq),
    .regfile_waddr_o (regfile_waddr), .regfile_wdata_o (regfile_wdata),
    .jump_req_o (jump_req), .jump_addr_o (jump_addr)
  );

  // register file model with combinational read --------------------
  assign regfile_rdata = rf_model[regfile_raddr];

  always @(posedge clk) begin
    if (regfile_wreq === 1'b1)
      rf_model[regfile_waddr] <= regfile_wdata;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  // compare tasks --------------------
  task automatic check_data(input logic [`DBG_DATA_W-1:0] got, exp, input string what);
    if (got !== exp)
      stop_run($sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_settings(input dbg_pkg::dbg_settings_t got, exp, input string what);
    if (got !== exp)
      stop_run($sformatf("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_jump(input logic req, input logic [`DBG_DATA_W-1:0] got, exp,
                            input string what);
    if (req !== 1'b1)
      stop_run($sformatf("Mismatch at %0t ns: %s jump_req_o low one cycle after write",
                         $time, what));
    else if (got !== exp)
      stop_run($sformatf("Mismatch at %0t ns: %s jump_addr_o %h expected %h",
                         $time, what, got, exp));
  endtask

  task automatic add_step(input op_e op, input logic [`DBG_ADDR_W-1:0] addr,
                          input logic [`DBG_DATA_W-1:0] data, input dbg_pkg::dbg_cause_t cause,
                          input logic [`DBG_DATA_W-1:0] exp);
    steps[n_steps] = '{op, addr, data, cause, exp};
    n_steps++;
  endtask

  // one bus access from a falling edge to the rvalid cycle
  task automatic bus_access(input logic we, input logic [`DBG_ADDR_W-1:0] addr,
                            input logic [`DBG_DATA_W-1:0] wdata);
    debug_req   = 1'b1;
    debug_we    = we;
    debug_addr  = addr;
    debug_wdata = wdata;
    @(posedge clk);
    if (debug_gnt !== 1'b1)
      stop_run("bus request was not granted in its own cycle");
    @(negedge clk);
    debug_req = 1'b0;
    debug_we  = 1'b0;
    while (debug_rvalid !== 1'b1)
      @(negedge clk);
    rd_word     = debug_rdata;
    rreq_seen   = regfile_rreq; // GPR read request sits in the rvalid cycle
    jump_seen   = jump_req; // jump follows the request by one cycle
    jump_target = jump_addr;
  endtask

  task automatic pulse_input(input op_e op, input dbg_pkg::dbg_cause_t cause);
    case (op)
      OP_HALT:   debug_halt   = 1'b1;
      OP_RESUME: debug_resume = 1'b1;
      OP_ACK:    dbg_ack      = 1'b1;
      default: begin
        trap      = 1'b1;
        exc_cause = cause;
      end
    endcase
    @(negedge clk);
    debug_halt   = 1'b0;
    debug_resume = 1'b0;
    dbg_ack      = 1'b0;
    trap         = 1'b0;
  endtask

  // stimulus table --------------------
  task automatic build_table();
    // after reset
    add_step(OP_RD,     15'h0000, '0, '0, 32'h0000_0000); // CTRL
    add_step(OP_RD,     15'h000C, '0, '0, 32'h0000_001F); // CAUSE reset value
    add_step(OP_SETS,   '0,       '0, '0, 32'h0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h0);
    // bus halt then ack
    add_step(OP_WR,     15'h0000, 32'h0001_0000, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h1);         // dbg_req only
    add_step(OP_ACK,    '0,       '0, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h6);         // halted and stall
    add_step(OP_RD,     15'h0000, '0, '0, 32'h0001_0000);
    add_step(OP_RD,     15'h000C, '0, '0, 32'h0000_001F);
    // IE write with elsu shown on bits 7 and 5
    add_step(OP_WR,     15'h0008, 32'h0000_0AAC, '0, '0);
    add_step(OP_RD,     15'h0008, '0, '0, 32'h0000_08AC);
    add_step(OP_SETS,   '0,       '0, '0, 32'h0F);        // ecall elsu ebrk eill
    // GPR x5 while halted
    add_step(OP_RND_WR, 15'h0414, '0, '0, '0);
    add_step(OP_MODEL,  15'h0414, '0, '0, '0);
    add_step(OP_RND_RD, 15'h0414, '0, '0, '0);
    // DNPC jump then bus resume
    add_step(OP_JUMP,   15'h2000, 32'h0000_0180, '0, '0);
    add_step(OP_WR,     15'h0000, 32'h0000_0000, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h0);
    add_step(OP_RD,     15'h0000, '0, '0, 32'h0000_0000);
    // GPR blocked while running
    add_step(OP_RD,     15'h0414, '0, '0, 32'h0000_0000);
    add_step(OP_WR,     15'h0414, 32'hDEAD_BEEF, '0, '0);
    add_step(OP_MODEL,  15'h0414, '0, '0, '0);            // untouched
    // single step on and a trap with cause 0x22
    add_step(OP_WR,     15'h0000, 32'h0000_0001, '0, '0);
    add_step(OP_SETS,   '0,       '0, '0, 32'h1F);
    add_step(OP_TRAP,   '0,       '0, 6'h22, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h1);
    add_step(OP_ACK,    '0,       '0, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h6);
    add_step(OP_RD,     15'h000C, '0, '0, 32'h8000_0002);
    add_step(OP_RD,     15'h0000, '0, '0, 32'h0001_0001);
    add_step(OP_RD,     15'h0004, '0, '0, 32'h0000_0001); // step hit
    add_step(OP_WR,     15'h0004, 32'h0000_0001, '0, '0);
    add_step(OP_RD,     15'h0004, '0, '0, 32'h0000_0000);
    // external pins resume from HALT and from HALT_REQ
    add_step(OP_RESUME, '0,       '0, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h0);
    add_step(OP_HALT,   '0,       '0, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h1);
    add_step(OP_RESUME, '0,       '0, '0, '0);
    add_step(OP_STAT,   '0,       '0, '0, 32'h0);
    add_step(OP_RD,     15'h000C, '0, '0, 32'h0000_001F); // non-trap halt cause
  endtask

  // watchdog --------------------
  initial begin : watchdog
    wait (table_ready === 1'b1);
    #(n_steps * 200 * CLK_PERIOD_NS);
    $display("Timeout: the test did not finish within %0d clock periods", n_steps * 200);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : run_steps
    step_t s;
    string what;
    int    i;
    debug_req    = 1'b0;
    debug_we     = 1'b0;
    debug_addr   = '0;
    debug_wdata  = '0;
    debug_halt   = 1'b0;
    debug_resume = 1'b0;
    trap         = 1'b0;
    exc_cause    = '0;
    dbg_ack      = 1'b0;
    rnd_word     = '0;
    for (i = 0; i < 32; i++)
      rf_model[i] = 32'hF00D_0000 | i; // index in the low bits
    build_table();
    table_ready = 1'b1;
    @(posedge rst_n);

    for (i = 0; i < n_steps; i++) begin
      @(negedge clk);
      s    = steps[i];
      what = $sformatf("step %0d", i);
      case (s.op)
        OP_WR: bus_access(1'b1, s.addr, s.data);
        OP_RD: begin
          bus_access(1'b0, s.addr, '0);
          check_data(rd_word, s.exp, {what, " bus read"});
          check_data({31'b0, rreq_seen}, 32'h0, {what, " regfile_rreq_o"});
        end
        OP_RND_WR: begin
          rnd_word = $random(seed);
          bus_access(1'b1, s.addr, rnd_word);
        end
        OP_RND_RD: begin
          bus_access(1'b0, s.addr, '0);
          check_data(rd_word, rnd_word, {what, " GPR read"});
          check_data({31'b0, rreq_seen}, 32'h1, {what, " regfile_rreq_o"});
        end
        OP_MODEL: check_data(rf_model[s.addr[6:2]], rnd_word, {what, " register file"});
        OP_JUMP: begin
          bus_access(1'b1, s.addr, s.data);
          check_jump(jump_seen, jump_target, s.data, {what, " DNPC write"});
        end
        OP_SETS: check_settings(settings, s.exp[`DBG_SETS_W-1:0], {what, " settings_o"});
        OP_STAT: check_data({29'b0, debug_halted, stall, dbg_req}, s.exp,
                            {what, " halted/stall/dbg_req"});
        default: pulse_input(s.op, s.cause);
      endcase
    end

    @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
dbg_pkg.sv
dbg_access_if.sv
dbg_status_if.sv
dbg_bus_decoder.sv
dbg_regs.sv
dbg_halt_ctrl.sv
dbg_unit_top.sv
tb_clk_gen.sv
tb_dbg_unit.sv

// File: Bender.yml
package:
  name: dbg_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dbg_pkg.sv
      - dbg_access_if.sv
      - dbg_status_if.sv
      - dbg_bus_decoder.sv
      - dbg_regs.sv
      - dbg_halt_ctrl.sv
      - dbg_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_dbg_unit.sv
